//--- hdl/fp64Pkg.sv
// Shared definitions for the FP64 conversion unit
// IEEE 754 double layout, raw word and step count types
// Opcode, controller state and operand class encodings
// Format constants and F2I saturation values

package fp64Pkg;

	// ======================================================================
	// Format constants
	// ======================================================================

	// Top bit index of the stored fraction and of the exponent field
	localparam int FMSB = 51;
	localparam int EMSB = 10;

	// Top bit of a raw 64-bit word
	localparam int WORD_MSB = 63;

	// Exponent bias, and the all-ones exponent used by infinity and NaN
	localparam logic [EMSB:0] EXP_BIAS = 11'd1023;
	localparam logic [EMSB:0] EXP_MAX = 11'd2047;

	// ======================================================================
	// Types
	// ======================================================================

	// Double precision value split into its three fields
	typedef struct packed {
		logic sign;
		logic [EMSB:0] exp;
		logic [FMSB:0] sig;
	} FP64;

	// Raw operand or result bits, either a double or a two's-complement integer
	typedef logic [WORD_MSB:0] cvtWord;

	// Shift step counts and bit positions from 0 to 64
	typedef logic [6:0] stepCnt;

	typedef enum logic [1:0] {
		OP_TRUNC = 2'd0,
		OP_F2I = 2'd1,
		OP_I2F = 2'd2
	} cvtOpE;

	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_SHIFT = 2'd1,
		ST_PACK = 2'd2,
		ST_DONE = 2'd3
	} cvtStateE;

	// Operand class as seen by the packer
	typedef enum logic [1:0] {
		CL_ZERO = 2'd0,
		CL_SAT = 2'd1,
		CL_NORMAL = 2'd2
	} cvtClassE;

	// I2F starts its leading-one search from the top bit
	localparam stepCnt I2F_STEPS = 7'd63;

	// Saturated F2I results for positive and negative overflow
	localparam cvtWord F2I_SAT_POS = {1'b0, {WORD_MSB{1'b1}}};
	localparam cvtWord F2I_SAT_NEG = {1'b1, {WORD_MSB{1'b0}}};

endpackage

//--- hdl/fpTrunc64.sv
// Truncation of a double to its integer part, single cycle latency
// Fraction bits below the binary point are masked off
// Overflow flags infinity and NaN, which pass through unchanged

`timescale 1ns/1ns

module fpTrunc64
	import fp64Pkg::*;
(
	input logic clk,
	input logic arstN,
	input logic ce,
	input FP64 i,
	output FP64 o,
	output logic overflow
);

	// Number of fraction bits that sit below the binary point, minus one
	logic [EMSB:0] shamt;
	logic [FMSB:0] mask;
	FP64 truncVal;

	// Only meaningful while the unbiased exponent is between 0 and FMSB
	assign shamt = 11'(FMSB) - (i.exp - EXP_BIAS);

	// Keep every fraction bit above the cut point
	always_comb begin
		for (int n = 0; n <= FMSB; n++) begin
			mask[n] = (n > shamt);
		end
	end

	always_comb begin
		truncVal = i;
		if (i.exp < EXP_BIAS) begin
			// Magnitude below one, the sign goes as well
			truncVal = '0;
		end else if (i.exp <= EXP_BIAS + 11'(FMSB)) begin
			truncVal.sig = i.sig & mask;
		end
		// Large values, infinity and NaN have no fractional bits to drop
	end

	always_ff @(posedge clk) begin
		if (ce) begin
			o <= truncVal;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			overflow <= 1'b0;
		end else if (ce) begin
			overflow <= (i.exp == EXP_MAX);
		end
	end

endmodule

//--- hdl/fpStepCounter.sv
// Loadable down-counter for the serial alignment steps
// Stops at zero and flags it for the controller

`timescale 1ns/1ns

module fpStepCounter
	import fp64Pkg::*;
(
	input logic clk,
	input logic arstN,
	input logic load,
	input stepCnt loadVal,
	input logic en,
	output stepCnt count,
	output logic cntZero
);

	// Load wins over a step in the same cycle
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			count <= '0;
		end else if (load) begin
			count <= loadVal;
		end else if (en && !cntZero) begin
			count <= count - 7'd1;
		end
	end

	// F2I alignment is finished once every step has been taken
	assign cntZero = (count == '0);

endmodule

//--- hdl/fpAlignShifter.sv
// Serial alignment shifter for F2I and I2F
// Holds a 64-bit mantissa or magnitude
// Shifts one bit per enabled cycle in the direction latched at load

`timescale 1ns/1ns

module fpAlignShifter
	import fp64Pkg::*;
(
	input logic clk,
	input logic arstN,
	input logic load,
	input cvtWord loadVal,
	input logic shiftLeft,
	input logic en,
	output cvtWord value,
	output logic msb
);

	// Direction captured with the value, held for the whole operation
	logic dirLeft;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			dirLeft <= 1'b0;
		end else if (load) begin
			dirLeft <= shiftLeft;
		end
	end

	// ======================================================================
	// Shift register
	// ======================================================================

	// Zero fill from either end
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			value <= '0;
		end else if (load) begin
			value <= loadVal;
		end else if (en) begin
			if (dirLeft) begin
				value <= {value[WORD_MSB-1:0], 1'b0};
			end else begin
				value <= {1'b0, value[WORD_MSB:1]};
			end
		end
	end

	// I2F normalisation stops when the leading one reaches the top
	assign msb = value[WORD_MSB];

endmodule

//--- hdl/fpCvtCtrl.sv
// Control FSM for the conversion unit
// Decodes and classifies the operand on start
// Sets up the shifter direction and the step count
// Runs the shift loop, then triggers packing and pulses done

`timescale 1ns/1ns

module fpCvtCtrl
	import fp64Pkg::*;
(
	input logic clk,
	input logic arstN,
	input logic start,
	input cvtOpE op,
	input cvtWord operand,
	input logic cntZero,
	input logic msb,
	output FP64 truncIn,
	output logic truncCe,
	output logic shiftLoad,
	output cvtWord shiftLoadVal,
	output logic shiftLeft,
	output logic shiftEn,
	output stepCnt cntLoadVal,
	output cvtOpE opReg,
	output logic sgnReg,
	output cvtClassE opClass,
	output logic packEn,
	output logic busy,
	output logic done
);

	cvtStateE state;
	cvtStateE nextState;
	FP64 fpIn;
	logic [EMSB:0] unbExp;
	cvtClassE decClass;
	logic accept;
	logic shiftStop;

	// ======================================================================
	// Operand decode, valid in the start cycle
	// ======================================================================

	assign fpIn = FP64'(operand);
	assign accept = (state == ST_IDLE) && start;

	// Only used while the exponent is at least the bias
	assign unbExp = fpIn.exp - EXP_BIAS;

	// The truncator sees the raw operand so TRUNC finishes in one cycle
	assign truncIn = fpIn;
	assign truncCe = accept && (op == OP_TRUNC);

	always_comb begin
		decClass = CL_NORMAL;
		shiftLoadVal = '0;
		shiftLeft = 1'b1;
		cntLoadVal = '0;
		case (op)
			OP_F2I: begin
				if (fpIn.exp < EXP_BIAS) begin
					decClass = CL_ZERO;
				end else if (fpIn.exp >= EXP_BIAS + 11'd63) begin
					// Too big for a signed 64-bit integer, also inf and NaN
					decClass = CL_SAT;
				end
				// Hidden one sits just above the fraction at bit 52
				shiftLoadVal = {11'd0, 1'b1, fpIn.sig};
				if (unbExp > 11'(FMSB)) begin
					shiftLeft = 1'b1;
					cntLoadVal = stepCnt'(unbExp - 11'(FMSB + 1));
				end else begin
					shiftLeft = 1'b0;
					cntLoadVal = stepCnt'(11'(FMSB + 1) - unbExp);
				end
			end
			OP_I2F: begin
				if (operand == '0) begin
					decClass = CL_ZERO;
				end
				// The most negative integer maps onto 2^63 here
				shiftLoadVal = operand[WORD_MSB] ? -operand : operand;
				cntLoadVal = I2F_STEPS;
			end
			OP_TRUNC: begin
				decClass = CL_NORMAL;
			end
			default: begin
				// Unused opcode just produces a zero result
				decClass = CL_ZERO;
			end
		endcase
	end

	// Counter load shares this strobe
	assign shiftLoad = accept && (op != OP_TRUNC);

	// ======================================================================
	// FSM
	// ======================================================================

	// F2I counts its steps down, I2F stops on the leading one
	assign shiftStop = (opReg == OP_F2I) ? cntZero : msb;

	always_comb begin
		nextState = state;
		case (state)
			ST_IDLE: begin
				if (start) begin
					if (op == OP_TRUNC) begin
						nextState = ST_DONE;
					end else if (decClass == CL_NORMAL) begin
						nextState = ST_SHIFT;
					end else begin
						nextState = ST_PACK;
					end
				end
			end
			ST_SHIFT: begin
				if (shiftStop) begin
					nextState = ST_PACK;
				end
			end
			ST_PACK: nextState = ST_DONE;
			default: nextState = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= ST_IDLE;
			opReg <= OP_TRUNC;
			sgnReg <= 1'b0;
			opClass <= CL_ZERO;
		end else begin
			state <= nextState;
			if (accept) begin
				opReg <= op;
				sgnReg <= operand[WORD_MSB];
				opClass <= decClass;
			end
		end
	end

	assign shiftEn = (state == ST_SHIFT) && !shiftStop;

	// TRUNC is packed on the done cycle, once the truncator has its result
	assign packEn = (state == ST_PACK) || ((state == ST_DONE) && (opReg == OP_TRUNC));

	assign busy = (state != ST_IDLE);
	assign done = (state == ST_DONE);

endmodule

//--- hdl/fpResultPack.sv
// Result assembly for all three opcodes
// F2I saturation and negation, I2F exponent and fraction assembly
// Registers the result word and overflow flag on packEn

`timescale 1ns/1ns

module fpResultPack
	import fp64Pkg::*;
(
	input logic clk,
	input logic arstN,
	input logic packEn,
	input cvtOpE opReg,
	input cvtClassE opClass,
	input logic sgnReg,
	input cvtWord value,
	input stepCnt count,
	input FP64 truncOut,
	input logic truncOvf,
	output cvtWord result,
	output logic overflow
);

	cvtWord packVal;
	logic packOvf;
	logic [EMSB:0] i2fExp;
	cvtWord resultReg;
	logic ovfReg;
	logic truncBypass;

	// Count holds the position of the leading one after I2F normalisation
	assign i2fExp = EXP_BIAS + {4'd0, count};

	always_comb begin
		packVal = '0;
		packOvf = 1'b0;
		case (opReg)
			OP_TRUNC: begin
				packVal = cvtWord'(truncOut);
				packOvf = truncOvf;
			end
			OP_F2I: begin
				case (opClass)
					CL_SAT: begin
						packVal = sgnReg ? F2I_SAT_NEG : F2I_SAT_POS;
						packOvf = 1'b1;
					end
					CL_NORMAL: begin
						packVal = sgnReg ? -value : value;
					end
					default: begin
						packVal = '0;
					end
				endcase
			end
			OP_I2F: begin
				// Leading one is implicit, the next 52 bits form the fraction
				if (opClass != CL_ZERO) begin
					packVal = {sgnReg, i2fExp, value[WORD_MSB-1 -: FMSB+1]};
				end
			end
			default: begin
				packVal = '0;
			end
		endcase
	end

	// ======================================================================
	// Output register
	// ======================================================================

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			resultReg <= '0;
			ovfReg <= 1'b0;
		end else if (packEn) begin
			resultReg <= packVal;
			ovfReg <= packOvf;
		end
	end

	// TRUNC shows its value in the done cycle it is packed in
	assign truncBypass = packEn && (opReg == OP_TRUNC);

	assign result = truncBypass ? packVal : resultReg;
	assign overflow = truncBypass ? packOvf : ovfReg;

endmodule

//--- hdl/fpCvtTop.sv
// Top level of the FP64 conversion unit
// Connects controller, step counter, shifter, truncator and packer

`timescale 1ns/1ns

module fpCvtTop
	import fp64Pkg::*;
(
	input logic clk,
	input logic arstN,
	input logic start,
	input cvtOpE op,
	input cvtWord operand,
	output cvtWord result,
	output logic overflow,
	output logic busy,
	output logic done
);

	// Controller outputs
	FP64 truncIn;
	logic truncCe;
	logic shiftLoad;
	cvtWord shiftLoadVal;
	logic shiftLeft;
	logic shiftEn;
	stepCnt cntLoadVal;
	cvtOpE opReg;
	logic sgnReg;
	cvtClassE opClass;
	logic packEn;

	// Datapath status and values
	stepCnt count;
	logic cntZero;
	cvtWord value;
	logic msb;
	FP64 truncOut;
	logic truncOvf;

	fpCvtCtrl uCtrl (
		.clk(clk),
		.arstN(arstN),
		.start(start),
		.op(op),
		.operand(operand),
		.cntZero(cntZero),
		.msb(msb),
		.truncIn(truncIn),
		.truncCe(truncCe),
		.shiftLoad(shiftLoad),
		.shiftLoadVal(shiftLoadVal),
		.shiftLeft(shiftLeft),
		.shiftEn(shiftEn),
		.cntLoadVal(cntLoadVal),
		.opReg(opReg),
		.sgnReg(sgnReg),
		.opClass(opClass),
		.packEn(packEn),
		.busy(busy),
		.done(done)
	);

	// Counter loads with the shifter and steps with it
	fpStepCounter uCnt (
		.clk(clk),
		.arstN(arstN),
		.load(shiftLoad),
		.loadVal(cntLoadVal),
		.en(shiftEn),
		.count(count),
		.cntZero(cntZero)
	);

	fpAlignShifter uShift (
		.clk(clk),
		.arstN(arstN),
		.load(shiftLoad),
		.loadVal(shiftLoadVal),
		.shiftLeft(shiftLeft),
		.en(shiftEn),
		.value(value),
		.msb(msb)
	);

	fpTrunc64 uTrunc (
		.clk(clk),
		.arstN(arstN),
		.ce(truncCe),
		.i(truncIn),
		.o(truncOut),
		.overflow(truncOvf)
	);

	fpResultPack uPack (
		.clk(clk),
		.arstN(arstN),
		.packEn(packEn),
		.opReg(opReg),
		.opClass(opClass),
		.sgnReg(sgnReg),
		.value(value),
		.count(count),
		.truncOut(truncOut),
		.truncOvf(truncOvf),
		.result(result),
		.overflow(overflow)
	);

endmodule

//--- tb/tb_fpCvt.sv
// Directed testbench for the FP64 conversion unit
// Reference models for TRUNC, F2I and I2F with latency prediction
// LFSR stimulus, typed compare tasks and a global cycle limit

`timescale 1ns/1ns

module tb_fpCvt
	import fp64Pkg::*;
();

	// Directed operations plus three opcodes per random operand and the busy tests
	localparam int NUM_OPS = 5 + 6 + 6 + 3 * 40 + 2;
	localparam int TIMEOUT_CYCLES = NUM_OPS * 70;
	// Longest operation is I2F of 1, 66 cycles
	localparam int DONE_WAIT = 70;

	logic clk;
	logic arstN;
	logic start;
	cvtOpE op;
	cvtWord operand;
	cvtWord result;
	logic overflow;
	logic busy;
	logic done;

	int checks;
	int valueErrors;
	int doneMisses;
	int cycleCnt;
	logic [31:0] lfsr;

	fpCvtTop u_dut (
		.clk(clk),
		.arstN(arstN),
		.start(start),
		.op(op),
		.operand(operand),
		.result(result),
		.overflow(overflow),
		.busy(busy),
		.done(done)
	);

	always #20 clk = ~clk;

	// Ends a run that stalls somewhere outside the per-operation wait
	always @(posedge clk) begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycleCnt);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// ======================================================================
	// Reference models
	// ======================================================================

	function automatic int leadPos(input cvtWord m);
		int p;
		p = 0;
		for (int b = 0; b < 64; b++) begin
			if (m[b]) p = b;
		end
		return p;
	endfunction

	function automatic cvtWord refTrunc(input cvtWord x, output logic ovf);
		FP64 f;
		FP64 r;
		int e;
		f = x;
		r = f;
		ovf = 1'b0;
		e = int'(f.exp) - 1023;
		if (f.exp == EXP_MAX) begin
			ovf = 1'b1;
		end else if (e < 0) begin
			r = '0;
		end else if (e < 52) begin
			// Clear the 52-e fraction bits that lie below the binary point
			r.sig = (f.sig >> (52 - e)) << (52 - e);
		end
		return r;
	endfunction

	function automatic cvtWord refF2I(input cvtWord x, output logic ovf);
		FP64 f;
		int e;
		cvtWord mag;
		cvtWord r;
		f = x;
		e = int'(f.exp) - 1023;
		ovf = 1'b0;
		r = '0;
		if (e >= 63) begin
			ovf = 1'b1;
			r = f.sign ? 64'h8000_0000_0000_0000 : 64'h7FFF_FFFF_FFFF_FFFF;
		end else if (e >= 0) begin
			mag = {11'd0, 1'b1, f.sig};
			if (e >= 52) mag = mag << (e - 52);
			else mag = mag >> (52 - e);
			r = f.sign ? -mag : mag;
		end
		return r;
	endfunction

	function automatic cvtWord refI2F(input cvtWord x);
		cvtWord mag;
		cvtWord norm;
		FP64 r;
		int p;
		r = '0;
		if (x != '0) begin
			mag = x[63] ? (~x + 64'd1) : x;
			p = leadPos(mag);
			// Bits below the 52 kept fraction bits are dropped, which truncates
			norm = mag << (63 - p);
			r.sign = x[63];
			r.exp = 11'(1023 + p);
			r.sig = norm[62:11];
		end
		return r;
	endfunction

	// Cycles from the start cycle to the done cycle
	function automatic stepCnt expLatency(input cvtOpE o, input cvtWord x);
		FP64 f;
		int e;
		f = x;
		e = int'(f.exp) - 1023;
		case (o)
			OP_TRUNC: return 7'd1;
			OP_F2I: begin
				if (e < 0 || e >= 63) return 7'd2;
				return stepCnt'(((e >= 52) ? e - 52 : 52 - e) + 3);
			end
			default: begin
				if (x == '0) return 7'd2;
				return stepCnt'(63 - leadPos(x[63] ? (~x + 64'd1) : x) + 3);
			end
		endcase
	endfunction

	// Taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic randBits(input int n, output cvtWord w);
		w = '0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsrNext(lfsr);
			w = {w[62:0], lfsr[0]};
		end
	endtask

	// ======================================================================
	// Compare tasks
	// ======================================================================

	task automatic checkWord(input string name, input cvtWord expVal, input cvtWord actVal);
		checks++;
		if (actVal !== expVal) begin
			$display("Fail at %0t: %s expected %h, got %h", $time, name, expVal, actVal);
			valueErrors++;
		end
	endtask

	task automatic checkBit(input string name, input logic expVal, input logic actVal);
		checks++;
		if (actVal !== expVal) begin
			$display("Fail at %0t: %s expected %b, got %b", $time, name, expVal, actVal);
			valueErrors++;
		end
	endtask

	task automatic checkSteps(input string name, input stepCnt expVal, input stepCnt actVal);
		checks++;
		if (actVal !== expVal) begin
			$display("Fail at %0t: %s expected %0d, got %0d", $time, name, expVal, actVal);
			valueErrors++;
		end
	endtask

	// ======================================================================
	// Operation driver
	// ======================================================================

	// Called on a falling edge, returns on the falling edge after done
	// With intrude set, a TRUNC start is pulsed while the operation is busy
	task automatic runOp(input cvtOpE opIn, input cvtWord val, input bit intrude);
		cvtWord expRes;
		logic expOvf;
		stepCnt expLat;
		int k;
		bit seen;
		expOvf = 1'b0;
		case (opIn)
			OP_TRUNC: expRes = refTrunc(val, expOvf);
			OP_F2I: expRes = refF2I(val, expOvf);
			default: expRes = refI2F(val);
		endcase
		expLat = expLatency(opIn, val);
		op = opIn;
		operand = val;
		start = 1'b1;
		k = 0;
		seen = 1'b0;
		while (!seen && k < DONE_WAIT) begin
			@(negedge clk);
			k++;
			if (k == 1) start = 1'b0;
			if (intrude && k == 4) begin
				start = 1'b1;
				op = OP_TRUNC;
				operand = $realtobits(3.75);
			end
			if (intrude && k == 5) start = 1'b0;
			checkBit("busy", 1'b1, busy);
			if (done) seen = 1'b1;
		end
		if (!seen) begin
			$display("No done pulse within %0d cycles for opcode %0d, operand %h",
				DONE_WAIT, opIn, val);
			doneMisses++;
		end else begin
			checkSteps("latency", expLat, stepCnt'(k));
			checkWord("result", expRes, result);
			checkBit("overflow", expOvf, overflow);
			// Done is a single pulse and the result holds afterwards
			@(negedge clk);
			checkBit("done", 1'b0, done);
			checkBit("busy", 1'b0, busy);
			checkWord("result", expRes, result);
			checkBit("overflow", expOvf, overflow);
		end
	endtask

	// ======================================================================
	// Tests
	// ======================================================================

	task automatic testReset();
		checkBit("busy", 1'b0, busy);
		checkBit("done", 1'b0, done);
		checkBit("overflow", 1'b0, overflow);
		checkWord("result", '0, result);
	endtask

	task automatic testTrunc();
		runOp(OP_TRUNC, $realtobits(3.75), 1'b0);
		runOp(OP_TRUNC, $realtobits(-2.5), 1'b0);
		runOp(OP_TRUNC, $realtobits(-0.5), 1'b0);
		runOp(OP_TRUNC, $realtobits(2.0 ** 60 + 0.5), 1'b0);
		runOp(OP_TRUNC, 64'h7FF0_0000_0000_0000, 1'b0);
	endtask

	task automatic testF2I();
		runOp(OP_F2I, $realtobits(0.9), 1'b0);
		runOp(OP_F2I, $realtobits(-7.99), 1'b0);
		runOp(OP_F2I, $realtobits(2.0 ** 52 + 3.0), 1'b0);
		runOp(OP_F2I, $realtobits(2.0 ** 62), 1'b0);
		runOp(OP_F2I, $realtobits(2.0 ** 63), 1'b0);
		runOp(OP_F2I, $realtobits(-1.0e30), 1'b0);
	endtask

	task automatic testI2F();
		runOp(OP_I2F, 64'd0, 1'b0);
		runOp(OP_I2F, 64'd1, 1'b0);
		runOp(OP_I2F, 64'hFFFF_FFFF_FFFF_FFFF, 1'b0);
		runOp(OP_I2F, 64'h0020_0000_0000_0001, 1'b0);
		runOp(OP_I2F, 64'h7FFF_FFFF_FFFF_FFFF, 1'b0);
		runOp(OP_I2F, 64'h8000_0000_0000_0000, 1'b0);
	endtask

	// F2I and TRUNC get an exponent steered near the conversion range
	task automatic testRandom();
		cvtWord w;
		cvtWord e7;
		cvtWord steered;
		for (int n = 0; n < 40; n++) begin
			randBits(64, w);
			randBits(7, e7);
			steered = {w[63], 11'(1013 + (e7 % 80)), w[51:0]};
			runOp(OP_TRUNC, steered, 1'b0);
			runOp(OP_F2I, steered, 1'b0);
			runOp(OP_I2F, w, 1'b0);
		end
	endtask

	task automatic testBusyStart();
		runOp(OP_I2F, 64'd1, 1'b1);
		runOp(OP_F2I, $realtobits(-3.0), 1'b1);
	endtask

	initial begin
		clk = 1'b0;
		arstN = 1'b0;
		start = 1'b0;
		op = OP_TRUNC;
		operand = '0;
		checks = 0;
		valueErrors = 0;
		doneMisses = 0;
		cycleCnt = 0;
		lfsr = 32'hca0f;
		repeat (3) @(negedge clk);
		arstN = 1'b1;
		testReset();
		testTrunc();
		testF2I();
		testI2F();
		testRandom();
		testBusyStart();
		$display("Checks %0d, value errors %0d, missing done %0d", checks, valueErrors,
			doneMisses);
		if (valueErrors == 0 && doneMisses == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- sim.f
hdl/fp64Pkg.sv
hdl/fpTrunc64.sv
hdl/fpStepCounter.sv
hdl/fpAlignShifter.sv
hdl/fpCvtCtrl.sv
hdl/fpResultPack.sv
hdl/fpCvtTop.sv
tb/tb_fpCvt.sv

//--- Bender.yml
package:
  name: fp_cvt

sources:
  # Package first, then leaf modules, then the top level
  - files:
      - hdl/fp64Pkg.sv
      - hdl/fpTrunc64.sv
      - hdl/fpStepCounter.sv
      - hdl/fpAlignShifter.sv
      - hdl/fpCvtCtrl.sv
      - hdl/fpResultPack.sv
      - hdl/fpCvtTop.sv

  # Testbench, only in simulation
  - target: test
    files:
      - tb/tb_fpCvt.sv
